//--- compile.f
+incdir+rtl
rtl/ppu_regs_pkg.sv
rtl/ppu_pixel_pkg.sv
rtl/ppu_apb_regs.sv
rtl/ppu_vram.sv
rtl/ppu_dot_timer.sv
rtl/bg_fetcher.sv
rtl/bg_pixel_fifo.sv
rtl/ppu_bg_top.sv
tb/ppu_bg_sva.sv
tb/ppu_bg_tb.sv

//--- rtl/bg_fetcher.sv
module bg_fetcher (
  input  logic                        clk,
  input  logic                        reset,
  input  ppu_regs_pkg::ppu_regs_t     regs,
  input  ppu_regs_pkg::ppu_timing_t   timing,
  input  logic [7:0]                  rdata,
  input  logic                        fifo_empty,
  output ppu_pixel_pkg::vram_rd_req_t rd_req,
  output logic                        push,
  output ppu_pixel_pkg::tile_row_t    row
);
  import ppu_regs_pkg::*;
  import ppu_pixel_pkg::*;

  typedef enum logic [1:0] {
    fetch_tile,
    fetch_low,
    fetch_high,
    fetch_push
  } fetch_state_e;

  fetch_state_e state;
  // Phase 0 issues the read, phase 1 latches rdata
  logic         phase;
  // Tile column relative to SCX/8
  logic [4:0]   fetch_x;
  tile_index_u  tile_idx;
  logic [7:0]   low_byte;
  logic [7:0]   high_byte;
  logic         drawing;
  logic [12:0]  map_base;
  logic [4:0]   map_x;
  logic [7:0]   map_y;
  logic [12:0]  map_addr;
  logic [12:0]  data_base;
  logic [12:0]  row_addr;

  assign drawing = timing.mode == mode_draw;

  // Background map, 32x32 entries
  assign map_base = regs.lcdc.bg_map_sel ? 13'h1C00 : 13'h1800;
  assign map_x    = regs.scx[7:3] + fetch_x;
  assign map_y    = regs.scy + timing.ly;
  assign map_addr = map_base + {3'd0, map_y[7:3], map_x};

  // Tile data, unsigned from 0x0000 or signed around 0x1000
  assign data_base = regs.lcdc.bg_tile_sel ? {1'b0, tile_idx.idx, 4'd0}
                                           : 13'h1000 + {tile_idx.sidx[7], tile_idx.sidx, 4'd0};
  // Two bytes per pixel row
  assign row_addr  = data_base + {9'd0, map_y[2:0], 1'b0};

  // Request is combinational so rdata lands in phase 1
  assign rd_req.req = drawing && !phase && (state != fetch_push);
  always_comb begin
    case (state)
      fetch_low:  rd_req.addr = row_addr;
      fetch_high: rd_req.addr = row_addr + 13'd1;
      default:    rd_req.addr = map_addr;
    endcase
  end

  // Whole row goes in at once, and only into an empty FIFO
  assign push = drawing && (state == fetch_push) && fifo_empty;

  // Leftmost pixel takes the MSBs
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      row[i] = {high_byte[7 - i], low_byte[7 - i]};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= fetch_tile;
      phase   <= 1'b0;
      fetch_x <= 5'd0;
    end else if (timing.line_start) begin
      // New line restarts at the SCX tile
      state   <= fetch_tile;
      phase   <= 1'b0;
      fetch_x <= 5'd0;
    end else if (drawing) begin
      if (state == fetch_push) begin
        // Retry every dot until the FIFO drains
        if (fifo_empty) begin
          state   <= fetch_tile;
          fetch_x <= fetch_x + 5'd1;
        end
      end else begin
        phase <= !phase;
        if (phase) begin
          case (state)
            fetch_tile: state <= fetch_low;
            fetch_low:  state <= fetch_high;
            default:    state <= fetch_push;
          endcase
        end
      end
    end
  end

  // Capture the bytes read in phase 0
  always_ff @(posedge clk) begin
    if (drawing && phase) begin
      case (state)
        fetch_tile: tile_idx.idx <= rdata;
        fetch_low:  low_byte     <= rdata;
        fetch_high: high_byte    <= rdata;
        default: ;
      endcase
    end
  end

endmodule

//--- rtl/bg_pixel_fifo.sv
`include "ppu_macros.svh"

module bg_pixel_fifo (
  input  logic                      clk,
  input  logic                      reset,
  input  ppu_regs_pkg::ppu_timing_t timing,
  input  ppu_regs_pkg::ppu_regs_t   regs,
  input  logic                      push,
  input  ppu_pixel_pkg::tile_row_t  row,
  output logic                      empty,
  output ppu_pixel_pkg::pixel_out_t pixel_out,
  output logic                      line_done
);
  import ppu_regs_pkg::*;
  import ppu_pixel_pkg::*;

  tile_row_t  shreg;
  logic [3:0] count;
  // Fine scroll pixels still to drop
  logic [2:0] discard;
  logic [7:0] x_cnt;
  logic       shift_en;
  logic       line_full;
  logic       pix_valid;
  color_t     raw;

  assign empty     = count == 4'd0;
  assign shift_en  = (timing.mode == mode_draw) && !empty;
  // Stop output once the line is complete
  assign line_full = x_cnt == 8'(`PPU_LINE_PIXELS);
  assign pix_valid = shift_en && (discard == 3'd0) && !line_full;
  assign raw       = shreg[0];

  // BGP lookup, code c picks bits 2c+1:2c
  assign pixel_out.valid = pix_valid;
  assign pixel_out.color = regs.bgp[{raw, 1'b0} +: 2];
  assign pixel_out.x     = x_cnt;
  assign pixel_out.ly    = timing.ly;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count     <= 4'd0;
      discard   <= 3'd0;
      x_cnt     <= 8'd0;
      line_done <= 1'b0;
    end else begin
      line_done <= pix_valid && (x_cnt == 8'(`PPU_LINE_PIXELS - 1));
      if (timing.line_start) begin
        count   <= 4'd0;
        discard <= regs.scx[2:0];
        x_cnt   <= 8'd0;
      end else if (push) begin
        count <= 4'd8;
      end else if (shift_en) begin
        count <= count - 4'd1;
        if (discard != 3'd0) begin
          discard <= discard - 3'd1;
        end
        if (pix_valid) begin
          x_cnt <= x_cnt + 8'd1;
        end
      end
    end
  end

  // Pixel data, oldest at entry 0
  always_ff @(posedge clk) begin
    if (push) begin
      shreg <= row;
    end else if (shift_en) begin
      shreg <= {color_t'(2'd0), shreg[7:1]};
    end
  end

endmodule

//--- rtl/ppu_apb_regs.sv
`include "ppu_macros.svh"

module ppu_apb_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [13:0]             paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [7:0]              pwdata,
  input  ppu_regs_pkg::ppu_mode_e mode,
  input  logic [7:0]              ly,
  input  logic [7:0]              cpu_rdata,
  output logic [7:0]              prdata,
  output logic                    pready,
  output logic                    pslverr,
  output ppu_regs_pkg::ppu_regs_t regs,
  output logic                    cpu_we,
  output logic                    cpu_re,
  output logic [12:0]             cpu_addr,
  output logic [7:0]              cpu_wdata
);
  import ppu_regs_pkg::*;

  logic        setup;
  logic        access;
  logic [13:0] reg_off;
  logic        is_vram;
  logic        is_reg;
  logic        blocked;
  logic [7:0]  reg_rdata;
  logic [7:0]  rd_data_q;
  logic        rd_vram_q;
  logic        err_q;

  // APB phases
  assign setup  = psel && !penable;
  assign access = psel && penable;

  // Address decode, offsets below the base wrap to large values
  assign reg_off = paddr - `PPU_REG_BASE;
  assign is_vram = paddr < `PPU_VRAM_TOP;
  assign is_reg  = reg_off < 14'd6;
  // CPU loses VRAM while the fetcher owns it
  assign blocked = is_vram && (mode == mode_draw);

  // Register read mux, offset 4 is LY and 5 the mode
  always_comb begin
    case (reg_off[2:0])
      3'd0:    reg_rdata = regs.lcdc;
      3'd1:    reg_rdata = regs.scy;
      3'd2:    reg_rdata = regs.scx;
      3'd3:    reg_rdata = regs.bgp;
      3'd4:    reg_rdata = ly;
      3'd5:    reg_rdata = {6'd0, mode};
      default: reg_rdata = 8'h00;
    endcase
  end

  // Decision and read data are taken in the setup phase
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_data_q <= 8'h00;
      rd_vram_q <= 1'b0;
      err_q     <= 1'b0;
    end else if (setup) begin
      err_q     <= blocked || !(is_vram || is_reg);
      rd_vram_q <= is_vram && !blocked && !pwrite;
      if (blocked) begin
        rd_data_q <= 8'hff;
      end else if (is_reg) begin
        rd_data_q <= reg_rdata;
      end else begin
        rd_data_q <= 8'h00;
      end
    end
  end

  // Register writes land in the access phase, LY and mode are read-only
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs <= '0;
    end else if (access && pwrite && is_reg && !err_q) begin
      case (reg_off[2:0])
        3'd0:    regs.lcdc <= lcdc_t'(pwdata);
        3'd1:    regs.scy  <= pwdata;
        3'd2:    regs.scx  <= pwdata;
        3'd3:    regs.bgp  <= pwdata;
        default: ;
      endcase
    end
  end

  // VRAM read goes out in setup so the data is there in access
  assign cpu_re    = setup && !pwrite && is_vram && !blocked;
  assign cpu_we    = access && pwrite && is_vram && !err_q;
  assign cpu_addr  = paddr[12:0];
  assign cpu_wdata = pwdata;

  // No wait states
  assign pready  = access;
  assign pslverr = access && err_q;
  assign prdata  = rd_vram_q ? cpu_rdata : rd_data_q;

endmodule

//--- rtl/ppu_bg_top.sv
module ppu_bg_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [13:0]               paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [7:0]                pwdata,
  output logic [7:0]                prdata,
  output logic                      pready,
  output logic                      pslverr,
  output ppu_pixel_pkg::pixel_out_t pixel_out
);
  import ppu_regs_pkg::*;
  import ppu_pixel_pkg::*;

  ppu_regs_t    regs;
  ppu_timing_t  timing;
  // CPU side of VRAM
  logic         cpu_we;
  logic         cpu_re;
  logic [12:0]  cpu_addr;
  logic [7:0]   cpu_wdata;
  logic [7:0]   cpu_rdata;
  // Fetcher side of VRAM
  vram_rd_req_t rd_req;
  logic [7:0]   vram_rdata;
  // Fetcher to FIFO
  logic         push;
  tile_row_t    row;
  logic         fifo_empty;
  logic         line_done;

  ppu_apb_regs u_apb (
    .clk      (clk),
    .reset    (reset),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .mode     (timing.mode),
    .ly       (timing.ly),
    .cpu_rdata(cpu_rdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .regs     (regs),
    .cpu_we   (cpu_we),
    .cpu_re   (cpu_re),
    .cpu_addr (cpu_addr),
    .cpu_wdata(cpu_wdata)
  );

  ppu_vram u_vram (
    .clk      (clk),
    .cpu_we   (cpu_we),
    .cpu_re   (cpu_re),
    .cpu_addr (cpu_addr),
    .cpu_wdata(cpu_wdata),
    .rd_req   (rd_req),
    .cpu_rdata(cpu_rdata),
    .rdata    (vram_rdata)
  );

  ppu_dot_timer u_timer (
    .clk      (clk),
    .reset    (reset),
    .line_done(line_done),
    .timing   (timing)
  );

  bg_fetcher u_fetcher (
    .clk       (clk),
    .reset     (reset),
    .regs      (regs),
    .timing    (timing),
    .rdata     (vram_rdata),
    .fifo_empty(fifo_empty),
    .rd_req    (rd_req),
    .push      (push),
    .row       (row)
  );

  bg_pixel_fifo u_fifo (
    .clk      (clk),
    .reset    (reset),
    .timing   (timing),
    .regs     (regs),
    .push     (push),
    .row      (row),
    .empty    (fifo_empty),
    .pixel_out(pixel_out),
    .line_done(line_done)
  );

endmodule

//--- rtl/ppu_dot_timer.sv
`include "ppu_macros.svh"

module ppu_dot_timer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      line_done,
  output ppu_regs_pkg::ppu_timing_t timing
);
  import ppu_regs_pkg::*;

  ppu_mode_e  mode;
  logic [6:0] dot;
  logic [7:0] ly;
  logic [7:0] ly_next;
  logic       last_dot;
  logic       last_scan_dot;

  assign last_dot      = dot == 7'(`PPU_LINE_DOTS - 1);
  assign last_scan_dot = (mode == mode_oam_scan) && (dot == 7'(`PPU_MODE2_LEN - 1));
  // Frame wraps after the last vblank line
  assign ly_next = (ly == 8'(`PPU_TOTAL_LINES - 1)) ? 8'd0 : ly + 8'd1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot  <= 7'd0;
      ly   <= 8'd0;
      mode <= mode_oam_scan;
    end else if (last_dot) begin
      dot <= 7'd0;
      ly  <= ly_next;
      // Visible lines open with the OAM scan
      mode <= (ly_next < 8'(`PPU_VISIBLE_LINES)) ? mode_oam_scan : mode_vblank;
    end else begin
      dot <= dot + 7'd1;
      case (mode)
        mode_oam_scan: begin
          if (last_scan_dot) begin
            mode <= mode_draw;
          end
        end
        // Draw length varies with fine scroll, FIFO tells us when it ends
        mode_draw: begin
          if (line_done) begin
            mode <= mode_hblank;
          end
        end
        default: ;
      endcase
    end
  end

  assign timing.mode       = mode;
  assign timing.ly         = ly;
  assign timing.dot        = dot;
  // Flush pulse for fetcher and FIFO
  assign timing.line_start = last_scan_dot;

endmodule

//--- rtl/ppu_macros.svh
`ifndef PPU_MACROS_SVH
`define PPU_MACROS_SVH

// Screen geometry, reduced for short simulations
// Full size is 160 pixels, 144 visible lines, 154 total lines
`define PPU_LINE_PIXELS   32
`define PPU_VISIBLE_LINES 4
`define PPU_TOTAL_LINES   6

// Dot budget of one line
`define PPU_MODE2_LEN     20
`define PPU_LINE_DOTS     120

// APB address map
`define PPU_VRAM_TOP      14'h2000
`define PPU_REG_BASE      14'h2040
`define PPU_VRAM_WORDS    8192

`endif

//--- rtl/ppu_pixel_pkg.sv
package ppu_pixel_pkg;

  // Raw two-bit color code before the palette
  typedef logic [1:0] color_t;

  // Tilemap entry, read either as unsigned or as signed offset
  typedef union packed {
    logic        [7:0] idx;
    logic signed [7:0] sidx;
  } tile_index_u;

  // One tile row, entry 0 is the leftmost pixel
  typedef color_t [7:0] tile_row_t;

  // Fetcher read port into VRAM
  typedef struct packed {
    logic        req;
    logic [12:0] addr;
  } vram_rd_req_t;

  // Screen pixel after palette mapping
  typedef struct packed {
    logic       valid;
    color_t     color;
    logic [7:0] x;
    logic [7:0] ly;
  } pixel_out_t;

endpackage

//--- rtl/ppu_regs_pkg.sv
package ppu_regs_pkg;

  // Mode encoding matches the STAT mode field
  typedef enum logic [1:0] {
    mode_hblank   = 2'd0,
    mode_vblank   = 2'd1,
    mode_oam_scan = 2'd2,
    mode_draw     = 2'd3
  } ppu_mode_e;

  // LCDC bit layout, MSB first
  typedef struct packed {
    logic lcd_en;
    logic win_map_sel;
    logic win_en;
    logic bg_tile_sel;   // 1: unsigned tiles at 0x0000, 0: signed around 0x1000
    logic bg_map_sel;    // 1: map at 0x1C00, 0: map at 0x1800
    logic obj_size;
    logic obj_en;
    logic bg_en;
  } lcdc_t;

  // CPU-writable register file
  typedef struct packed {
    lcdc_t      lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] bgp;
  } ppu_regs_t;

  // Timer state broadcast to every block
  typedef struct packed {
    ppu_mode_e  mode;
    logic [7:0] ly;
    logic [6:0] dot;
    logic       line_start;
  } ppu_timing_t;

endpackage

//--- rtl/ppu_vram.sv
`include "ppu_macros.svh"

module ppu_vram (
  input  logic                       clk,
  input  logic                       cpu_we,
  input  logic                       cpu_re,
  input  logic [12:0]                cpu_addr,
  input  logic [7:0]                 cpu_wdata,
  input  ppu_pixel_pkg::vram_rd_req_t rd_req,
  output logic [7:0]                 cpu_rdata,
  output logic [7:0]                 rdata
);

  // Byte-wide video RAM
  logic [7:0] mem [`PPU_VRAM_WORDS];

  // CPU port, write and registered read
  always_ff @(posedge clk) begin
    if (cpu_we) begin
      mem[cpu_addr] <= cpu_wdata;
    end
    if (cpu_re) begin
      cpu_rdata <= mem[cpu_addr];
    end
  end

  // Fetcher port is read-only
  // Data shows up the dot after the request
  always_ff @(posedge clk) begin
    if (rd_req.req) begin
      rdata <= mem[rd_req.addr];
    end
  end

endmodule

//--- tb/ppu_bg_sva.sv
`include "ppu_macros.svh"

module ppu_bg_sva (
  input logic                        clk,
  input logic                        reset,
  input ppu_regs_pkg::ppu_timing_t   timing,
  input ppu_pixel_pkg::vram_rd_req_t rd_req,
  input logic                        push,
  input logic                        fifo_empty,
  input ppu_pixel_pkg::pixel_out_t   pixel_out
);

  // Assertion failures seen so far
  int unsigned violations = 0;

  // A pushed tile row is in the FIFO on the next dot
  push_loads_row: assert property (@(posedge clk) disable iff (reset) push |=> !fifo_empty)
    else begin
      $error("FIFO still empty on the dot after a push");
      violations++;
    end

  // Fetcher reads only after the OAM scan of a visible line
  req_in_draw: assert property (@(posedge clk) disable iff (reset)
    rd_req.req |-> (timing.dot >= 7'(`PPU_MODE2_LEN)) &&
                   (timing.ly < 8'(`PPU_VISIBLE_LINES)))
    else begin
      $error("fetcher VRAM request outside the draw window");
      violations++;
    end

  // First pixel needs three reads of two dots, the push and the load
  pixel_in_draw: assert property (@(posedge clk) disable iff (reset)
    pixel_out.valid |-> (timing.dot >= 7'(`PPU_MODE2_LEN + 7)) &&
                        (timing.ly < 8'(`PPU_VISIBLE_LINES)))
    else begin
      $error("pixel output valid outside the draw window");
      violations++;
    end

endmodule

// Fetcher and FIFO handshake as wired in the top level
bind ppu_bg_top ppu_bg_sva u_sva (
  .clk       (clk),
  .reset     (reset),
  .timing    (timing),
  .rd_req    (rd_req),
  .push      (push),
  .fifo_empty(fifo_empty),
  .pixel_out (pixel_out)
);

//--- tb/ppu_bg_tb.sv
`include "ppu_macros.svh"

module ppu_bg_tb;
  import ppu_pixel_pkg::*;

  logic        clk;
  logic        reset;
  logic [13:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;
  logic        pslverr;
  pixel_out_t  pixel_out;

  // Parsed trace, one entry per command
  string       cmd_q[$];
  int          arg0_q[$];
  int          arg1_q[$];
  int          arg2_q[$];
  string       name_q[$];

  int          pass_count = 0;
  int          error_count = 0;
  int          test_errors = 0;
  int          budget_dots = 0;
  bit          budget_ready = 1'b0;
  // Last frame seen on the pixel output
  pixel_out_t  captured [`PPU_VISIBLE_LINES][`PPU_LINE_PIXELS];
  int          line_cnt = 0;
  bit          line_seen = 1'b0;
  event        frame_done;

  ppu_bg_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .pixel_out(pixel_out)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s (time %0t)", msg, $time);
    error_count++;
    test_errors++;
  endtask

  task automatic check_byte(input string what, input logic [7:0] got, input logic got_err,
                            input logic [7:0] exp, input logic exp_err);
    if (got !== exp || got_err !== exp_err) begin
      $display("Error at %0t: %s read %h err %b, expected %h err %b",
               $time, what, got, got_err, exp, exp_err);
      error_count++;
      test_errors++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_pixel(input pixel_out_t got, input pixel_out_t exp);
    if (got !== exp) begin
      $display("Error at %0t: pixel ly %0d x %0d got valid %b color %0d, expected color %0d",
               $time, exp.ly, exp.x, got.valid, got.color, exp.color);
      error_count++;
      test_errors++;
    end else begin
      pass_count++;
    end
  endtask

  // One APB transfer, setup then access, no wait states expected
  task automatic apb_transfer(input logic [13:0] addr, input logic write,
                              input logic [7:0] wdata, output logic [7:0] rdata,
                              output logic err);
    @(posedge clk);
    #1;
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    if (pready !== 1'b1) begin
      report_failure($sformatf("APB access phase at %h saw pready low", addr));
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Poll the mode byte until the timer reaches the wanted mode
  task automatic wait_for_mode(input int mode);
    logic [7:0] rd;
    logic       err;
    rd = 8'hff;
    while (rd != mode[7:0]) begin
      apb_transfer(`PPU_REG_BASE + 14'd5, 1'b0, 8'h00, rd, err);
    end
  endtask

  // Finish the frame in flight, then capture one whole frame
  task automatic wait_for_frame();
    foreach (captured[l, x]) begin
      captured[l][x] = '0;
    end
    @(frame_done);
    @(frame_done);
  endtask

  // Pixel monitor, also checks x order and pixels per line
  always @(negedge clk) begin
    if (!reset && pixel_out.valid) begin
      if (pixel_out.x == 8'd0) begin
        if (line_seen && line_cnt != `PPU_LINE_PIXELS) begin
          report_failure($sformatf("a line ended after %0d pixels", line_cnt));
        end
        line_cnt  = 0;
        line_seen = 1'b1;
      end
      if (pixel_out.x != line_cnt) begin
        report_failure($sformatf("pixel x %0d arrived where x %0d was due", pixel_out.x,
                                 line_cnt));
      end
      line_cnt++;
      if (pixel_out.ly < `PPU_VISIBLE_LINES && pixel_out.x < `PPU_LINE_PIXELS) begin
        captured[pixel_out.ly][pixel_out.x] = pixel_out;
      end
      if (pixel_out.ly == `PPU_VISIBLE_LINES - 1 && pixel_out.x == `PPU_LINE_PIXELS - 1) begin
        -> frame_done;
      end
    end
  end

  // Watchdog, sized from the parsed trace
  initial begin
    wait (budget_ready);
    #(budget_dots * 10);
    $display("Timeout: the trace did not finish within %0d clock cycles", budget_dots);
    $display("Test failed");
    $finish;
  end

  initial begin
    int         fd;
    int         code;
    int         a0;
    int         a1;
    int         a2;
    int         sva_errors;
    string      cmd;
    string      text;
    logic [7:0] rd;
    logic       err;
    pixel_out_t exp;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    reset   = 1'b1;
    fd = $fopen("tb/ppu_bg_trace.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the trace file tb/ppu_bg_trace.txt");
    end else begin
      while ($fscanf(fd, "%s", cmd) == 1) begin
        a0 = 0;
        a1 = 0;
        a2 = 0;
        text = "";
        // Fields still missing after the scan
        code = 0;
        if (cmd == "#") begin
          code = $fgets(text, fd);
          continue;
        end else if (cmd == "W") begin
          code = $fscanf(fd, "%h %h", a0, a1) - 2;
        end else if (cmd == "R") begin
          code = $fscanf(fd, "%h %h %d", a0, a1, a2) - 3;
        end else if (cmd == "P") begin
          code = $fscanf(fd, "%d %d %d", a0, a1, a2) - 3;
        end else if (cmd == "M") begin
          code = $fscanf(fd, "%d", a0) - 1;
        end else if (cmd == "T") begin
          code = $fscanf(fd, "%s", text) - 1;
        end
        if (code != 0) begin
          report_failure($sformatf("trace command %s is missing fields", cmd));
        end
        cmd_q.push_back(cmd);
        arg0_q.push_back(a0);
        arg1_q.push_back(a1);
        arg2_q.push_back(a2);
        name_q.push_back(text);
        // Mode and frame waits may take up to a frame each
        if (cmd == "M" || cmd == "F") begin
          budget_dots += 3 * `PPU_TOTAL_LINES * `PPU_LINE_DOTS;
        end else begin
          budget_dots += 8;
        end
      end
      $fclose(fd);
    end
    budget_dots += 2 * `PPU_LINE_DOTS;
    budget_ready = 1'b1;

    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    foreach (cmd_q[i]) begin
      if (cmd_q[i] == "W") begin
        apb_transfer(arg0_q[i][13:0], 1'b1, arg1_q[i][7:0], rd, err);
      end else if (cmd_q[i] == "R") begin
        apb_transfer(arg0_q[i][13:0], 1'b0, 8'h00, rd, err);
        check_byte($sformatf("APB %h", arg0_q[i][13:0]), rd, err, arg1_q[i][7:0],
                   arg2_q[i][0]);
      end else if (cmd_q[i] == "M") begin
        wait_for_mode(arg0_q[i]);
      end else if (cmd_q[i] == "F") begin
        wait_for_frame();
      end else if (cmd_q[i] == "P") begin
        exp.valid = 1'b1;
        exp.ly    = arg0_q[i][7:0];
        exp.x     = arg1_q[i][7:0];
        exp.color = arg2_q[i][1:0];
        if (arg0_q[i] >= `PPU_VISIBLE_LINES || arg1_q[i] >= `PPU_LINE_PIXELS) begin
          report_failure($sformatf("trace asks for pixel ly %0d x %0d off the screen",
                                   arg0_q[i], arg1_q[i]));
        end else begin
          check_pixel(captured[arg0_q[i]][arg1_q[i]], exp);
        end
      end else if (cmd_q[i] == "T") begin
        if (test_errors == 0) begin
          $display("%s: passed", name_q[i]);
        end else begin
          $display("%s: %0d errors", name_q[i], test_errors);
        end
        test_errors = 0;
      end else begin
        report_failure($sformatf("unknown trace command %s", cmd_q[i]));
      end
    end

    sva_errors = u_dut.u_sva.violations;
    if (sva_errors != 0) begin
      $display("%0d assertion violations were seen during the run", sva_errors);
    end
    error_count += sva_errors;
    $display("Checks passed: %0d, errors: %0d", pass_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tb/ppu_bg_trace.txt
# W addr data | R addr data err | P ly x color | M mode | F (next full frame) | T name
# addr and data in hex, everything else decimal
W 2041 5A
W 2042 A5
W 2043 1B
W 2040 91
R 2040 91 0
R 2041 5A 0
R 2042 A5 0
R 2043 1B 0
M 1
R 2044 04 0
R 2045 01 0
R 2046 00 1
R 3000 00 1
T register_readback
M 1
W 0000 3C
R 0000 3C 0
M 3
R 0000 FF 1
W 0000 C3
M 0
R 0000 3C 0
T vram_blocking
# map 0x1800 cols 0 and 1, tile rows at 0x0010, 0x1010 and 0x0810
M 1
W 1800 01
W 1801 81
W 0010 55
W 0011 33
W 1010 F0
W 1011 F0
W 0810 00
W 0811 FF
W 2041 00
W 2042 00
W 2043 1B
W 2040 91
F
P 0 0 3
P 0 1 2
P 0 2 1
P 0 3 0
P 0 9 1
T unsigned_tiles
W 2040 81
F
P 0 0 0
P 0 5 3
P 0 12 1
T signed_tiles
# SCY wraps line 1 onto map row 0, SCX wraps map column 31 onto 0
W 2041 FF
W 2042 FD
F
P 1 3 0
P 1 7 3
P 1 11 1
T scrolling
M 1
W 1C00 81
W 1C01 01
W 2041 00
W 2042 00
W 2043 E4
W 2040 89
F
P 0 0 2
P 0 4 2
P 0 8 3
P 0 12 0
T map_and_palette
